/* iob_pkg.sv */
package iob_pkg;

	typedef logic [7:0]  byte_t;     // one link byte
	typedef logic [15:0] word_t;     // bus address / data
	typedef logic [3:0]  nb_t;       // block number
	typedef logic [3:0]  cmd_code_t;

	// request codes (host -> bridge, or bridge -> host for S/F)
	localparam cmd_code_t CMD_PA  = 4'd0;
	localparam cmd_code_t CMD_W   = 4'd2;
	localparam cmd_code_t CMD_R   = 4'd3;
	localparam cmd_code_t CMD_S   = 4'd4;
	localparam cmd_code_t CMD_F   = 4'd5;
	localparam cmd_code_t CMD_IN  = 4'd6;
	localparam cmd_code_t CMD_CPD = 4'd8;
	localparam cmd_code_t CMD_CPR = 4'd9;
	localparam cmd_code_t CMD_CPF = 4'd10;
	// response codes
	localparam cmd_code_t CMD_EN  = 4'd1;
	localparam cmd_code_t CMD_OK  = 4'd2;
	localparam cmd_code_t CMD_PE  = 4'd3;

	localparam int MSG_MAX = 6; // longest message in bytes

	typedef struct packed {
		logic      req;  // request flag, bit 7 of cmd byte
		cmd_code_t code;
		logic      pn;   // a1 bit 4
		nb_t       nb;   // a1 bits 3..0
		word_t     ad;
		word_t     dt;
	} msg_t;

	typedef struct packed {
		logic  dpa, dw, dr, din, dok, den, dpe;
		logic  dpn;
		nb_t   dnb;
		word_t dad;
		word_t ddt;
	} bus_drv_t;

	typedef struct packed {
		logic  rs, rf, rok, rpe;
		logic  rpn;
		nb_t   rnb;
		word_t rad;
		word_t rdt;
	} bus_rcv_t;

	typedef struct packed {
		word_t keys;
		nb_t   rotary_out;
		logic  rotary_trig;
		nb_t   fn;
		logic  fn_v;
		logic  fn_trig;
		logic  keys_trig;
	} cp_out_t;

	// bytes in a message, cmd byte included
	function automatic logic [2:0] msg_len(input logic req, input cmd_code_t code);
		if (req) begin
			case (code)
				CMD_PA, CMD_W, CMD_R, CMD_IN, CMD_S, CMD_F: return 3'd6;
				CMD_CPD:          return 3'd3; // cmd, keys hi, keys lo
				CMD_CPR, CMD_CPF: return 3'd2; // cmd, a1
				default:          return 3'd1;
			endcase
		end
		return (code == CMD_OK) ? 3'd6 : 3'd1; // EN, PE and unknown are bare
	endfunction

endpackage

/* msg_rx.sv */
module msg_rx (
	input  logic           clk_sys,
	input  logic           rst_n,
	input  iob_pkg::byte_t rx_byte,
	input  logic           rx_valid,
	input  logic           rx_release,
	output logic           rx_credit,
	output iob_pkg::msg_t  rx_msg,
	output logic           rx_msg_valid
);
	import iob_pkg::*;

	logic [2:0] idx;      // position of next byte in message
	logic [2:0] len_q;    // length of message being assembled / held
	logic [2:0] len_now;
	logic [2:0] ret_cnt;  // credits still to hand back
	logic       take;
	logic       last;
	logic       is_cpd;

	// first byte decides the length, later bytes use the latched one
	assign len_now = (idx == 3'd0) ? msg_len(rx_byte[7], rx_byte[3:0]) : len_q;
	assign last    = (idx == len_now - 3'd1);
	assign take    = rx_valid && !rx_msg_valid && (ret_cnt == 3'd0);
	assign is_cpd  = rx_msg.req && (rx_msg.code == CMD_CPD); // keys follow cmd directly

	assign rx_credit = (ret_cnt != 3'd0);

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			idx          <= '0;
			len_q        <= '0;
			ret_cnt      <= '0;
			rx_msg_valid <= 1'b0;
		end else begin
			if (take) begin
				if (idx == 3'd0)
					len_q <= len_now;
				if (last) begin
					idx          <= '0;
					rx_msg_valid <= 1'b1; // held until released
				end else begin
					idx <= idx + 3'd1;
				end
			end
			if (rx_release) begin
				rx_msg_valid <= 1'b0;
				ret_cnt      <= len_q; // one credit per byte freed
			end else if (ret_cnt != 3'd0) begin
				ret_cnt <= ret_cnt - 3'd1;
			end
		end
	end

	// byte steering into msg fields
	always_ff @(posedge clk_sys) begin
		if (take) begin
			case (idx)
				3'd0: begin
					rx_msg.req  <= rx_byte[7];
					rx_msg.code <= rx_byte[3:0];
				end
				3'd1: begin
					if (is_cpd) begin
						rx_msg.dt[15:8] <= rx_byte;
					end else begin
						rx_msg.pn <= rx_byte[4];
						rx_msg.nb <= rx_byte[3:0];
					end
				end
				3'd2: begin
					if (is_cpd)
						rx_msg.dt[7:0] <= rx_byte;
					else
						rx_msg.ad[15:8] <= rx_byte;
				end
				3'd3: rx_msg.ad[7:0]  <= rx_byte;
				3'd4: rx_msg.dt[15:8] <= rx_byte;
				3'd5: rx_msg.dt[7:0]  <= rx_byte;
				default: ;
			endcase
		end
	end

	// host must wait for its credits, buffer holds one message only
	a_no_overrun: assert property (@(posedge clk_sys) disable iff (!rst_n)
		rx_valid |-> (!rx_msg_valid && ret_cnt == 3'd0));

endmodule

/* msg_tx.sv */
module msg_tx #(
	parameter int TX_CREDITS = 4
) (
	input  logic           clk_sys,
	input  logic           rst_n,
	input  iob_pkg::msg_t  tx_msg,
	input  logic           tx_send,
	input  logic           tx_credit,
	output logic           tx_busy,
	output iob_pkg::byte_t tx_byte,
	output logic           tx_valid
);
	import iob_pkg::*;

	localparam int CW = $clog2(TX_CREDITS + 1);

	msg_t       msg_q;
	logic [2:0] idx;     // next byte to go out
	logic [2:0] len_q;
	logic [CW-1:0] cnt;  // bytes the host can still take
	logic       can_send;

	assign can_send = tx_busy && (idx != len_q) && (cnt != '0);

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			tx_busy  <= 1'b0;
			tx_valid <= 1'b0;
			idx      <= '0;
			len_q    <= '0;
			cnt      <= CW'(TX_CREDITS);
		end else begin
			tx_valid <= can_send;
			if (tx_send) begin
				tx_busy <= 1'b1;
				idx     <= '0;
				len_q   <= msg_len(tx_msg.req, tx_msg.code);
			end else if (can_send) begin
				idx <= idx + 3'd1;
			end else if (tx_busy && idx == len_q) begin
				tx_busy <= 1'b0; // last byte went out last cycle
			end
			case ({can_send, tx_credit})
				2'b10:   cnt <= cnt - 1'b1;
				2'b01:   cnt <= cnt + 1'b1;
				default: ; // spent and returned together
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (tx_send)
			msg_q <= tx_msg;
		if (can_send) begin
			case (idx)
				3'd0:    tx_byte <= {msg_q.req, 3'b000, msg_q.code};
				3'd1:    tx_byte <= {3'b000, msg_q.pn, msg_q.nb};
				3'd2:    tx_byte <= msg_q.ad[15:8];
				3'd3:    tx_byte <= msg_q.ad[7:0];
				3'd4:    tx_byte <= msg_q.dt[15:8];
				default: tx_byte <= msg_q.dt[7:0];
			endcase
		end
	end

	// host gives back no more credit than bytes it was sent
	a_credit_bound: assert property (@(posedge clk_sys) disable iff (!rst_n)
		tx_credit |-> (cnt < CW'(TX_CREDITS)));
	a_send_idle: assert property (@(posedge clk_sys) disable iff (!rst_n)
		tx_send |-> !tx_busy);

endmodule

/* iob_ctrl.sv */
module iob_ctrl (
	input  logic             clk_sys,
	input  logic             rst_n,
	input  iob_pkg::msg_t    rx_msg,
	input  logic             rx_msg_valid,
	input  logic             tx_busy,
	input  iob_pkg::bus_rcv_t rcv,
	input  logic             zw,
	output logic             rx_release,
	output iob_pkg::msg_t    tx_msg,
	output logic             tx_send,
	output logic             cp_load,
	output iob_pkg::bus_drv_t bus,
	output logic             zg
);
	import iob_pkg::*;

	typedef enum logic [3:0] {
		S_IDLE,
		S_GRANT,   // zg up, waiting for zw
		S_STROBE,  // request on the bus, waiting for rok/rpe
		S_PA,      // single dpa cycle
		S_TXW,     // response going to host
		S_BWAIT,   // S/F sent, waiting for host answer
		S_BHOLD,   // answer on bus until rs/rf drop
		S_CP,      // panel load
		S_REL      // release cycle, msg_rx drops valid
	} state_t;

	state_t state;
	logic   host_bus;  // host request for the bus
	logic   host_cp;   // host panel command
	logic   bus_req;   // request from the system bus

	assign host_bus = rx_msg.req && (rx_msg.code == CMD_PA || rx_msg.code == CMD_W ||
		rx_msg.code == CMD_R || rx_msg.code == CMD_IN);
	assign host_cp  = rx_msg.req && (rx_msg.code == CMD_CPD || rx_msg.code == CMD_CPR ||
		rx_msg.code == CMD_CPF);
	assign bus_req  = (rcv.rs || rcv.rf) && !rcv.rad[15]; // upper half is not ours

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			state      <= S_IDLE;
			zg         <= 1'b0;
			bus        <= '0;
			tx_send    <= 1'b0;
			cp_load    <= 1'b0;
			rx_release <= 1'b0;
		end else begin
			tx_send    <= 1'b0; // pulses
			cp_load    <= 1'b0;
			rx_release <= 1'b0;
			case (state)
				S_IDLE: begin
					if (rx_msg_valid) begin // host first, bus side waits on rs/rf
						if (host_bus) begin
							zg    <= 1'b1;
							state <= S_GRANT;
						end else if (host_cp) begin
							cp_load <= 1'b1;
							state   <= S_CP;
						end else begin
							rx_release <= 1'b1; // stray response, drop it
							state      <= S_REL;
						end
					end else if (bus_req) begin
						tx_msg  <= '{req: 1'b1, code: rcv.rs ? CMD_S : CMD_F, pn: rcv.rpn,
							nb: rcv.rnb, ad: rcv.rad, dt: rcv.rdt};
						tx_send <= 1'b1;
						state   <= S_BWAIT;
					end
				end
				S_GRANT: begin
					if (zw) begin
						bus.dpn <= rx_msg.pn;
						bus.dnb <= rx_msg.nb;
						bus.dad <= rx_msg.ad;
						bus.ddt <= rx_msg.dt;
						bus.dpa <= (rx_msg.code == CMD_PA);
						bus.dw  <= (rx_msg.code == CMD_W);
						bus.dr  <= (rx_msg.code == CMD_R);
						bus.din <= (rx_msg.code == CMD_IN);
						state   <= (rx_msg.code == CMD_PA) ? S_PA : S_STROBE;
					end
				end
				S_PA: begin // interrupt needs no answer
					bus        <= '0;
					zg         <= 1'b0;
					rx_release <= 1'b1;
					state      <= S_REL;
				end
				S_STROBE: begin
					if (rcv.rok || rcv.rpe) begin
						bus     <= '0;
						tx_msg  <= '{req: 1'b0, code: rcv.rok ? CMD_OK : CMD_PE, pn: rcv.rpn,
							nb: rcv.rnb, ad: rcv.rad, dt: rcv.rdt};
						tx_send <= 1'b1;
						state   <= S_TXW;
					end
				end
				S_TXW: begin
					// busy rises a cycle after the send pulse
					if (!tx_send && !tx_busy) begin
						zg         <= 1'b0;
						rx_release <= 1'b1;
						state      <= S_REL;
					end
				end
				S_BWAIT: begin
					if (rx_msg_valid && !rx_msg.req) begin // host request here just waits
						bus.den <= (rx_msg.code == CMD_EN);
						bus.dpe <= (rx_msg.code == CMD_PE);
						if (rx_msg.code == CMD_OK) begin
							bus.dok <= 1'b1;
							bus.dpn <= rx_msg.pn;
							bus.dnb <= rx_msg.nb;
							bus.dad <= rx_msg.ad;
							bus.ddt <= rx_msg.dt;
						end
						state <= S_BHOLD;
					end
				end
				S_BHOLD: begin
					if (!rcv.rs && !rcv.rf) begin
						bus        <= '0;
						rx_release <= 1'b1;
						state      <= S_REL;
					end
				end
				S_CP: begin // cp_port took the message
					rx_release <= 1'b1;
					state      <= S_REL;
				end
				default: state <= S_IDLE; // S_REL
			endcase
		end
	end

	a_one_strobe: assert property (@(posedge clk_sys) disable iff (!rst_n)
		$onehot0({bus.dw, bus.dr, bus.din, bus.dpa, bus.dok, bus.den, bus.dpe}));

endmodule

/* cp_port.sv */
module cp_port (
	input  logic             clk_sys,
	input  logic             rst_n,
	input  iob_pkg::msg_t    rx_msg,
	input  logic             cp_load,
	output iob_pkg::cp_out_t cp
);
	import iob_pkg::*;

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			cp <= '0;
		end else begin
			cp.keys_trig   <= 1'b0; // triggers last one cycle
			cp.rotary_trig <= 1'b0;
			cp.fn_trig     <= 1'b0;
			if (cp_load) begin
				case (rx_msg.code)
					CMD_CPD: begin
						cp.keys      <= rx_msg.dt;
						cp.keys_trig <= 1'b1;
					end
					CMD_CPR: begin
						cp.rotary_out  <= rx_msg.nb;
						cp.rotary_trig <= 1'b1;
					end
					CMD_CPF: begin
						cp.fn      <= rx_msg.nb;
						cp.fn_v    <= rx_msg.pn; // pn bit carries fn valid
						cp.fn_trig <= 1'b1;
					end
					default: ;
				endcase
			end
		end
	end

endmodule

/* iobus.sv */
module iobus #(
	parameter int TX_CREDITS = 4
) (
	input  logic              clk_sys,
	input  logic              rst_n,
	input  iob_pkg::byte_t    rx_byte,
	input  logic              rx_valid,
	output logic              rx_credit,
	output iob_pkg::byte_t    tx_byte,
	output logic              tx_valid,
	input  logic              tx_credit,
	output iob_pkg::bus_drv_t bus,
	input  iob_pkg::bus_rcv_t rcv,
	output logic              zg,
	input  logic              zw,
	output iob_pkg::cp_out_t  cp
);
	import iob_pkg::*;

	msg_t rx_msg;        // held host message
	logic rx_msg_valid;
	logic rx_release;
	msg_t tx_msg;        // outgoing S/F/OK/PE
	logic tx_send;
	logic tx_busy;
	logic cp_load;

	msg_rx u_rx (
		.clk_sys, .rst_n, .rx_byte, .rx_valid, .rx_release,
		.rx_credit, .rx_msg, .rx_msg_valid
	);

	msg_tx #(.TX_CREDITS(TX_CREDITS)) u_tx (
		.clk_sys, .rst_n, .tx_msg, .tx_send, .tx_credit,
		.tx_busy, .tx_byte, .tx_valid
	);

	iob_ctrl u_ctrl (
		.clk_sys, .rst_n, .rx_msg, .rx_msg_valid, .tx_busy, .rcv, .zw,
		.rx_release, .tx_msg, .tx_send, .cp_load, .bus, .zg
	);

	cp_port u_cp (
		.clk_sys, .rst_n, .rx_msg, .cp_load, .cp
	);

endmodule

/* tb_iobus.sv */
module tb_iobus;
	timeunit 1ns;
	timeprecision 100ps;
	import iob_pkg::*;

	localparam int TX_CREDITS  = 4;
	localparam int CYCLE_LIMIT = 3000; // six tests at ~200 cycles, with margin

	logic     clk_sys = 1'b0;
	logic     rst_n;
	byte_t    rx_byte;
	logic     rx_valid;
	logic     rx_credit;
	byte_t    tx_byte;
	logic     tx_valid;
	logic     tx_credit = 1'b0;
	bus_drv_t bus;
	bus_rcv_t rcv;
	logic     zg;
	logic     zw;
	cp_out_t  cp;

	int      cycles = 0;
	int      errors = 0;
	int      passed = 0;
	int      failed = 0;
	int      seed = 44896;
	int      delay;
	int      host_credits = MSG_MAX; // host side receive credit
	int      bytes_sent = 0;
	int      credits_back = 0;
	int      tx_room = TX_CREDITS;   // bytes the bridge may still send
	bit      hold_credit = 1'b0;     // host stops returning tx credit
	byte_t   tx_q[$];                // bytes from the bridge
	int      credit_due[$];          // cycle each tx credit goes back
	int      keys_pulses = 0;
	int      rotary_pulses = 0;
	int      fn_pulses = 0;
	cp_out_t exp_cp;

	iobus #(.TX_CREDITS(TX_CREDITS)) DUT (.*);

	always #5 clk_sys = ~clk_sys;

	// link and panel monitor, mid-cycle so all DUT outputs are settled
	always @(negedge clk_sys) begin
		cycles++;
		if (rx_valid) begin
			host_credits--; // one credit per byte sent
			bytes_sent++;
		end
		if (rx_credit) begin
			host_credits++;
			credits_back++;
		end
		if (tx_valid) begin
			tx_q.push_back(tx_byte);
			delay = $unsigned($random(seed)) % 6; // 0..5 cycles
			credit_due.push_back(cycles + delay);
			tx_room--;
			if (tx_room < 0) begin
				$display("transmitter sent a byte without credit at %0t", $time);
				errors++;
			end
		end
		if (tx_credit)
			tx_room++;
		if (cp.keys_trig)
			keys_pulses++;
		if (cp.rotary_trig)
			rotary_pulses++;
		if (cp.fn_trig)
			fn_pulses++;
	end

	// host gives tx credit back, one per cycle at most
	always @(posedge clk_sys) begin
		#1;
		tx_credit = 1'b0;
		if (!hold_credit && credit_due.size() > 0 && credit_due[0] <= cycles) begin
			tx_credit = 1'b1;
			void'(credit_due.pop_front());
		end
	end

	always @(posedge clk_sys) begin
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout after %0d cycles, DUT stopped responding", cycles);
			$display("TEST FAILED");
			$finish;
		end
	end

	task automatic step();
		@(posedge clk_sys);
		#1; // drive just after the edge
	endtask

	task automatic step_n(input int n);
		repeat (n) step();
	endtask

	task automatic check_msg(input string name, input msg_t got, input msg_t exp);
		if (got !== exp) begin
			$display("FAIL t=%0t %s: got %h expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_bus(input string name, input bus_drv_t got, input bus_drv_t exp);
		if (got !== exp) begin
			$display("FAIL t=%0t %s: got %h expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_cp(input string name, input cp_out_t got, input cp_out_t exp);
		if (got !== exp) begin
			$display("FAIL t=%0t %s: got %h expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		if (got != exp) begin
			$display("FAIL t=%0t %s: got %0d expected %0d", $time, name, got, exp);
			errors++;
		end
	endtask

	function automatic msg_t make_msg(input logic req, input cmd_code_t code, input logic pn,
		input nb_t nb, input word_t ad, input word_t dt);
		return '{req, code, pn, nb, ad, dt};
	endfunction

	// request fields as they should show on the bus, no strobe yet
	function automatic bus_drv_t fields_bus(input msg_t m);
		bus_drv_t b;
		b     = '0;
		b.dpn = m.pn;
		b.dnb = m.nb;
		b.dad = m.ad;
		b.ddt = m.dt;
		return b;
	endfunction

	// cmd, a1, ad hi/lo, dt hi/lo; missing bytes read as zero
	function automatic msg_t collected_msg();
		byte_t b[6];
		foreach (b[i])
			b[i] = (i < tx_q.size()) ? tx_q[i] : 8'h00;
		return '{b[0][7], b[0][3:0], b[1][4], b[1][3:0], {b[2], b[3]}, {b[4], b[5]}};
	endfunction

	// host model, one message, never a byte without credit
	task automatic send_msg(input msg_t m, input int n);
		byte_t b[6];
		b[0] = {m.req, 3'b000, m.code};
		b[1] = {3'b000, m.pn, m.nb};
		b[2] = m.ad[15:8];
		b[3] = m.ad[7:0];
		b[4] = m.dt[15:8];
		b[5] = m.dt[7:0];
		if (m.req && m.code == CMD_CPD) begin // keys right after cmd
			b[1] = m.dt[15:8];
			b[2] = m.dt[7:0];
		end
		while (host_credits != MSG_MAX) // buffer holds one message
			step();
		for (int i = 0; i < n; i++) begin
			while (host_credits == 0)
				step();
			rx_byte  = b[i];
			rx_valid = 1'b1;
			step();
			rx_valid = 1'b0;
		end
	endtask

	task automatic wait_tx_bytes(input int n);
		while (tx_q.size() < n)
			step();
	endtask

	task automatic release_grant();
		while (zg)
			step();
		zw = 1'b0;
	endtask

	// host request through grant, strobe and bus answer
	task automatic bus_cycle(input msg_t m, input bus_drv_t exp_bus, input bus_rcv_t answer);
		send_msg(m, 6);
		while (!zg)
			step();
		step_n(2); // arbiter latency
		zw = 1'b1;
		while (!(bus.dw || bus.dr || bus.din))
			step();
		check_bus("bus strobe", bus, exp_bus);
		step_n(2);
		check_bus("bus strobe held", bus, exp_bus);
		rcv = answer;
		while (bus.dw || bus.dr || bus.din)
			step();
		rcv = '0; // answer seen for one edge
		check_bus("bus after answer", bus, '0);
	endtask

	task automatic end_test(input int num, input string name, input int err0);
		int n;
		n = 0;
		while (host_credits != MSG_MAX && n < 20) begin
			step();
			n++;
		end
		check_count("host rx credits", host_credits, MSG_MAX);
		if (errors == err0) begin
			passed++;
			$display("test %0d %s: ok", num, name);
		end else begin
			failed++;
			$display("test %0d %s: %0d errors", num, name, errors - err0);
		end
	endtask

	task automatic test_host_write();
		int       err0;
		msg_t     m;
		bus_drv_t eb;
		bus_rcv_t ans;
		err0 = errors;
		tx_q.delete();
		m     = make_msg(1'b1, CMD_W, 1'b1, 4'h5, 16'h1234, 16'hABCD);
		eb    = fields_bus(m);
		eb.dw = 1'b1;
		ans     = '0;
		ans.rok = 1'b1;
		ans.rpn = 1'b1;
		ans.rnb = 4'h9;
		ans.rad = 16'h0246;
		ans.rdt = 16'h5A5A;
		bus_cycle(m, eb, ans);
		wait_tx_bytes(6);
		release_grant();
		check_msg("ok response", collected_msg(),
			make_msg(1'b0, CMD_OK, 1'b1, 4'h9, 16'h0246, 16'h5A5A));
		check_count("ok response bytes", tx_q.size(), 6);
		end_test(1, "host write", err0);
	endtask

	task automatic test_read_error_pa();
		int       err0;
		msg_t     m;
		bus_drv_t eb;
		bus_rcv_t ans;
		err0 = errors;
		tx_q.delete();
		m     = make_msg(1'b1, CMD_R, 1'b0, 4'h2, 16'h0F00, 16'h0000);
		eb    = fields_bus(m);
		eb.dr = 1'b1;
		ans     = '0;
		ans.rpe = 1'b1; // parity error on read
		ans.rad = 16'h0F00;
		ans.rdt = 16'h1111;
		bus_cycle(m, eb, ans);
		release_grant();
		check_msg("pe response", collected_msg(), make_msg(1'b0, CMD_PE, 1'b0, 4'h0, 16'h0, 16'h0));
		check_count("pe response bytes", tx_q.size(), 1);
		tx_q.delete();
		m      = make_msg(1'b1, CMD_PA, 1'b1, 4'hA, 16'h0040, 16'h0003);
		eb     = fields_bus(m);
		eb.dpa = 1'b1;
		send_msg(m, 6);
		while (!zg)
			step();
		zw = 1'b1;
		while (!bus.dpa)
			step();
		check_bus("dpa strobe", bus, eb);
		step();
		check_bus("bus after dpa", bus, '0); // exactly one cycle
		check_count("zg after dpa", zg, 0);
		zw = 1'b0;
		step_n(12);
		check_count("bytes after pa", tx_q.size(), 0);
		end_test(2, "read error and pa", err0);
	endtask

	task automatic test_bus_side();
		int       err0;
		msg_t     m;
		bus_drv_t eb;
		err0 = errors;
		tx_q.delete();
		rcv     = '0;
		rcv.rs  = 1'b1;
		rcv.rpn = 1'b1;
		rcv.rnb = 4'h3;
		rcv.rad = 16'h0124;
		rcv.rdt = 16'hBEEF;
		wait_tx_bytes(6);
		check_msg("s request", collected_msg(),
			make_msg(1'b1, CMD_S, 1'b1, 4'h3, 16'h0124, 16'hBEEF));
		m      = make_msg(1'b0, CMD_OK, 1'b1, 4'hC, 16'h0124, 16'h7788);
		eb     = fields_bus(m);
		eb.dok = 1'b1;
		send_msg(m, 6);
		while (!bus.dok)
			step();
		check_bus("ok on bus", bus, eb);
		step_n(4);
		check_bus("ok held while rs", bus, eb);
		rcv.rs = 1'b0;
		while (bus.dok)
			step();
		check_bus("bus after rs drop", bus, '0);
		tx_q.delete();
		rcv     = '0;
		rcv.rf  = 1'b1;
		rcv.rnb = 4'h1;
		rcv.rad = 16'h0300;
		rcv.rdt = 16'h0042;
		wait_tx_bytes(6);
		check_msg("f request", collected_msg(),
			make_msg(1'b1, CMD_F, 1'b0, 4'h1, 16'h0300, 16'h0042));
		send_msg(make_msg(1'b0, CMD_EN, 1'b0, 4'h0, 16'h0, 16'h0), 1);
		while (!bus.den)
			step();
		eb     = '0;
		eb.den = 1'b1;
		check_bus("en on bus", bus, eb);
		rcv.rf = 1'b0;
		while (bus.den)
			step();
		check_bus("bus after rf drop", bus, '0);
		tx_q.delete();
		rcv     = '0;
		rcv.rs  = 1'b1;
		rcv.rad = 16'h8010; // upper half, not for the bridge
		step_n(20);
		check_count("bytes for upper address", tx_q.size(), 0);
		check_bus("bus for upper address", bus, '0);
		rcv = '0;
		end_test(3, "bus side request", err0);
	endtask

	// one panel command, then outputs and pulse counts
	task automatic panel_cmd(input msg_t m, input int n, input int k, input int r, input int f);
		send_msg(m, n);
		while (host_credits != MSG_MAX)
			step();
		check_cp("panel outputs", cp, exp_cp);
		check_count("keys_trig pulses", keys_pulses, k);
		check_count("rotary_trig pulses", rotary_pulses, r);
		check_count("fn_trig pulses", fn_pulses, f);
	endtask

	task automatic test_panel();
		int err0;
		err0 = errors;
		exp_cp.keys = 16'hC3A5;
		panel_cmd(make_msg(1'b1, CMD_CPD, 1'b0, 4'h0, 16'h0, 16'hC3A5), 3, 1, 0, 0);
		exp_cp.rotary_out = 4'h7;
		panel_cmd(make_msg(1'b1, CMD_CPR, 1'b1, 4'h7, 16'h0, 16'h0), 2, 1, 1, 0);
		exp_cp.fn   = 4'hB;
		exp_cp.fn_v = 1'b1;
		panel_cmd(make_msg(1'b1, CMD_CPF, 1'b1, 4'hB, 16'h0, 16'h0), 2, 1, 1, 1);
		exp_cp.fn   = 4'h4;
		exp_cp.fn_v = 1'b0; // function cleared
		panel_cmd(make_msg(1'b1, CMD_CPF, 1'b0, 4'h4, 16'h0, 16'h0), 2, 1, 1, 2);
		end_test(4, "control panel", err0);
	endtask

	task automatic test_backpressure();
		int       err0;
		msg_t     m;
		bus_drv_t eb;
		bus_rcv_t ans;
		err0 = errors;
		while (tx_room != TX_CREDITS) // all earlier credit home
			step();
		tx_q.delete();
		hold_credit = 1'b1;
		m     = make_msg(1'b1, CMD_W, 1'b0, 4'h1, 16'h2000, 16'h0F0F);
		eb    = fields_bus(m);
		eb.dw = 1'b1;
		ans     = '0;
		ans.rok = 1'b1;
		ans.rpn = 1'b1;
		ans.rnb = 4'h6;
		ans.rad = 16'h2000;
		ans.rdt = 16'hC0DE;
		bus_cycle(m, eb, ans);
		wait_tx_bytes(TX_CREDITS);
		step_n(20);
		check_count("bytes with credit withheld", tx_q.size(), TX_CREDITS);
		check_count("zg during stall", zg, 1);
		hold_credit = 1'b0;
		wait_tx_bytes(6);
		release_grant();
		check_msg("ok after stall", collected_msg(),
			make_msg(1'b0, CMD_OK, 1'b1, 4'h6, 16'h2000, 16'hC0DE));
		check_count("ok after stall bytes", tx_q.size(), 6);
		end_test(5, "transmit back-pressure", err0);
	endtask

	task automatic test_rx_credits();
		int err0;
		err0 = errors;
		check_count("rx credit pulses against bytes sent", credits_back, bytes_sent);
		end_test(6, "receive credits", err0);
	endtask

	initial begin
		rst_n    = 1'b0;
		rx_byte  = '0;
		rx_valid = 1'b0;
		rcv      = '0;
		zw       = 1'b0;
		exp_cp   = '0; // panel reset state
		repeat (8) @(posedge clk_sys);
		#1;
		rst_n = 1'b1;
		step();
		test_host_write();
		test_read_error_pa();
		test_bus_side();
		test_panel();
		test_backpressure();
		test_rx_credits();
		$display("tests: %0d passed, %0d failed, %0d check errors", passed, failed, errors);
		if (errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

/* iobus.f */
iob_pkg.sv
msg_rx.sv
msg_tx.sv
iob_ctrl.sv
cp_port.sv
iobus.sv
tb_iobus.sv

/* run.sh */
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal --top-module tb_iobus -f iobus.f \
	&& ./obj_dir/Vtb_iobus | grep -F "TEST PASSED" \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
